// ==== Bender.yml ====
package:
  name: fetch_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_pkg.sv
      - common/line_fill_if.sv
      - fetch/fetch_addr_gen.sv
      - fetch/ibuff_align.sv
      - fetch/fetch_pointer.sv
      - source/fetch_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/fetch_assertions.sv
      - dv/fetch_tb.sv

// ==== common/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// fetch unit sizing
////////////////////////////////////////////////////////////

// bytes per instruction line
`define FETCH_LINE_BYTES 16

// byte address width of the fetch pointer
`define FETCH_FIP_WIDTH 32

// fetch pointer value out of reset
`define FETCH_RESET_ADDR 32'h0000_1000

`endif

// ==== common/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // derived widths
    localparam int unsigned FIP_W = `FETCH_FIP_WIDTH;
    localparam int unsigned OFFSET_W = $clog2(`FETCH_LINE_BYTES);
    localparam int unsigned LINE_BITS = `FETCH_LINE_BYTES * 8;
    localparam int unsigned LINE_IDX_W = FIP_W - OFFSET_W;

    // byte address into instruction memory
    typedef logic [FIP_W-1:0] fip_t;

    // line index, bit 0 picks the bank
    typedef logic [LINE_IDX_W-1:0] line_addr_t;

    // byte k sits at bits 8k+7:8k
    typedef logic [LINE_BITS-1:0] line_t;

    // decoded instruction length, 1 to 16
    typedef logic [4:0] length_t;

endpackage

`default_nettype wire

// ==== common/line_fill_if.sv ====
`default_nettype none

// line fills and slot status, address gen to instruction buffer
interface line_fill_if;

    // one-cycle write strobes
    logic even_we;
    logic odd_we;

    // fill data, valid with the strobe
    fetch_pkg::line_t even_line;
    fetch_pkg::line_t odd_line;

    // slot holds the line the pointer needs now
    logic even_ready;
    logic odd_ready;

    modport gen (
        output even_we,
        output odd_we,
        output even_line,
        output odd_line,
        output even_ready,
        output odd_ready
    );

    modport buff (
        input even_we,
        input odd_we,
        input even_line,
        input odd_line,
        input even_ready,
        input odd_ready
    );

endinterface

`default_nettype wire

// ==== dv/fetch_assertions.sv ====
`default_nettype none

module fetch_assertions (
    input wire clk,
    input wire arst_n_i,
    input wire init_i,
    input wire resteer_i,
    input wire bp_taken_i,
    input wire stall_i,
    input wire fetch_pkg::line_t packet_i,
    input wire packet_valid_i,
    input wire fetch_pkg::fip_t packet_fip_i,
    input wire even_req_i,
    input wire even_ack_i,
    input wire odd_req_i,
    input wire odd_ack_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // request in flight per bank
    logic even_out_q;
    logic odd_out_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            even_out_q <= 1'b0;
            odd_out_q <= 1'b0;
        end else begin
            if (even_req_i) begin
                even_out_q <= 1'b1;
            end else if (even_ack_i) begin
                even_out_q <= 1'b0;
            end
            if (odd_req_i) begin
                odd_out_q <= 1'b1;
            end else if (odd_ack_i) begin
                odd_out_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // port properties
    ////////////////////////////////////////////////////////////

    even_one_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        even_req_i |-> !even_out_q)
        else $error("even bank requested again before its ack");

    odd_one_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        odd_req_i |-> !odd_out_q)
        else $error("odd bank requested again before its ack");

    stall_holds_packet: assert property (@(posedge clk) disable iff (!arst_n_i)
        packet_valid_i && stall_i |=>
            !packet_valid_i || ($stable(packet_i) && $stable(packet_fip_i)))
        else $error("packet changed while stalled");

    redirect_blocks_packet: assert property (@(posedge clk) disable iff (!arst_n_i)
        (init_i || resteer_i || bp_taken_i) |-> !packet_valid_i)
        else $error("packet valid in a redirect cycle");

endmodule

bind fetch_top fetch_assertions u_assertions (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .init_i(init_i),
    .resteer_i(resteer_i),
    .bp_taken_i(bp_taken_i),
    .stall_i(stall_i),
    .packet_i(packet_o),
    .packet_valid_i(packet_valid_o),
    .packet_fip_i(packet_fip_o),
    .even_req_i(imem_even_req_o),
    .even_ack_i(imem_even_ack_i),
    .odd_req_i(imem_odd_req_o),
    .odd_ack_i(imem_odd_ack_i)
);

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // packet count over all tests for the watchdog
    localparam int unsigned TOTAL_PKTS = 351;
    localparam longint unsigned WATCHDOG_NS = TOTAL_PKTS * 16 * 100 + 100000;
    localparam int unsigned PKT_WAIT_CYCLES = 300;

    logic clk;
    logic arst_n;
    logic init;
    logic resteer;
    logic bp_taken;
    logic stall;
    fetch_pkg::fip_t init_addr;
    fetch_pkg::fip_t wb_fip;
    fetch_pkg::fip_t bp_target;
    fetch_pkg::length_t d_length;
    fetch_pkg::line_t packet;
    logic packet_valid;
    fetch_pkg::fip_t packet_fip;

    // index 0 is the even bank and 1 the odd bank
    logic [1:0] mem_req;
    fetch_pkg::line_addr_t mem_addr [2];
    logic [1:0] mem_ack;
    fetch_pkg::line_t mem_line [2];
    logic [1:0] mem_busy;
    fetch_pkg::line_addr_t mem_tag [2];
    int unsigned mem_wait [2];
    logic hold_even;

    logic [31:0] rng_state = 32'd86256;
    fetch_pkg::fip_t exp_fip;

    fetch_top dut (
        .clk(clk),
        .arst_n_i(arst_n),
        .init_i(init),
        .init_addr_i(init_addr),
        .resteer_i(resteer),
        .wb_fip_i(wb_fip),
        .bp_taken_i(bp_taken),
        .bp_target_i(bp_target),
        .stall_i(stall),
        .d_length_i(d_length),
        .packet_o(packet),
        .packet_valid_o(packet_valid),
        .packet_fip_o(packet_fip),
        .imem_even_req_o(mem_req[0]),
        .imem_even_addr_o(mem_addr[0]),
        .imem_even_ack_i(mem_ack[0]),
        .imem_even_line_i(mem_line[0]),
        .imem_odd_req_o(mem_req[1]),
        .imem_odd_addr_o(mem_addr[1]),
        .imem_odd_ack_i(mem_ack[1]),
        .imem_odd_line_i(mem_line[1])
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_between(input int unsigned lo, input int unsigned hi);
        rng_state = xorshift32(rng_state);
        return lo + (rng_state % (hi - lo + 1));
    endfunction

    // memory byte at a is a[7:0] ^ a[15:8]
    function automatic fetch_pkg::line_t bytes_from(input fetch_pkg::fip_t base);
        fetch_pkg::line_t l;
        fetch_pkg::fip_t a;
        for (int k = 0; k < 16; k++) begin
            a = base + k;
            l[8*k +: 8] = a[7:0] ^ a[15:8];
        end
        return l;
    endfunction

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Test FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // instruction memory model
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_ack <= '0;
            mem_busy <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                mem_ack[b] <= 1'b0;
                if (mem_busy[b]) begin
                    if (mem_wait[b] > 1) begin
                        mem_wait[b] <= mem_wait[b] - 1;
                    end else if (!(b == 0 && hold_even)) begin
                        mem_ack[b] <= 1'b1;
                        mem_line[b] <= bytes_from({mem_tag[b], 4'h0});
                        mem_busy[b] <= 1'b0;
                    end
                end
                if (mem_req[b]) begin
                    if (mem_busy[b]) begin
                        abort_run("a memory bank was requested again before its ack");
                    end
                    mem_busy[b] <= 1'b1;
                    mem_tag[b] <= mem_addr[b];
                    mem_wait[b] <= rand_between(1, 6);
                end
            end
        end
    end

    // take n packets and check address and bytes on every valid cycle
    task automatic run_stream(input int unsigned n_pkts, input bit with_stall);
        int unsigned taken;
        int unsigned idle;
        int unsigned stall_left;
        fetch_pkg::length_t len;
        logic stall_now;
        taken = 0;
        idle = 0;
        stall_left = 0;
        stall_now = 1'b0;
        len = fetch_pkg::length_t'(rand_between(1, 16));
        stall <= 1'b0;
        d_length <= len;
        while (taken < n_pkts) begin
            @(posedge clk);
            if (packet_valid) begin
                check_equal(packet_fip, exp_fip, "packet address");
                check_equal(packet, bytes_from(exp_fip), "packet bytes");
                idle = 0;
                if (!stall_now) begin
                    exp_fip = exp_fip + len;
                    taken++;
                    len = fetch_pkg::length_t'(rand_between(1, 16));
                end
            end else begin
                idle++;
                if (idle > PKT_WAIT_CYCLES) begin
                    abort_run("no valid packet came from the fetch unit");
                end
            end
            if (stall_left > 0) begin
                stall_left--;
            end else if (with_stall && rand_between(0, 3) == 0) begin
                stall_left = rand_between(1, 8);
            end
            // freeze the stream once done
            stall_now = (stall_left > 0) || (taken == n_pkts);
            stall <= stall_now;
            d_length <= len;
        end
    endtask

    // one-cycle redirect that must block the packet in its cycle
    task automatic apply_redirect(input logic do_init, input logic do_resteer,
                                  input logic do_bp, input fetch_pkg::fip_t target);
        init <= do_init;
        resteer <= do_resteer;
        bp_taken <= do_bp;
        @(posedge clk);
        check_equal(packet_valid, 1'b0, "packet valid during a redirect");
        init <= 1'b0;
        resteer <= 1'b0;
        bp_taken <= 1'b0;
        exp_fip = target;
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic reset_and_first_packet;
        arst_n <= 1'b0;
        repeat (10) begin
            @(posedge clk);
            check_equal(mem_req, 2'b00, "memory request during reset");
            check_equal(packet_valid, 1'b0, "packet valid during reset");
        end
        arst_n <= 1'b1;
        exp_fip = `FETCH_RESET_ADDR;
        run_stream(1, 1'b0);
    endtask

    task automatic sequential_stream;
        run_stream(200, 1'b0);
    endtask

    task automatic stalled_stream;
        run_stream(100, 1'b1);
    endtask

    task automatic redirect_priority;
        fetch_pkg::fip_t a_init;
        fetch_pkg::fip_t a_wb;
        fetch_pkg::fip_t a_bp;
        a_init = 32'h0000_2345;
        a_wb = 32'h0000_5a0b;
        a_bp = 32'h0001_7f3e;
        init_addr <= a_init;
        wb_fip <= a_wb;
        bp_target <= a_bp;
        apply_redirect(1'b1, 1'b1, 1'b1, a_init);
        run_stream(10, 1'b0);
        apply_redirect(1'b0, 1'b1, 1'b1, a_wb);
        run_stream(10, 1'b0);
        apply_redirect(1'b0, 1'b0, 1'b1, a_bp);
        run_stream(10, 1'b0);
    endtask

    // even bank held back while the pointer moves far away
    task automatic stale_line_discard;
        hold_even <= 1'b1;
        bp_target <= 32'h0000_3004;
        apply_redirect(1'b0, 1'b0, 1'b1, 32'h0000_3004);
        repeat (4) @(posedge clk);
        bp_target <= 32'h0000_7a48;
        apply_redirect(1'b0, 1'b0, 1'b1, 32'h0000_7a48);
        repeat (30) begin
            @(posedge clk);
            check_equal(packet_valid, 1'b0, "packet valid while the even line is held back");
        end
        hold_even <= 1'b0;
        run_stream(20, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        arst_n = 1'b1;
        init = 1'b0;
        resteer = 1'b0;
        bp_taken = 1'b0;
        stall = 1'b1;
        init_addr = '0;
        wb_fip = '0;
        bp_target = '0;
        d_length = 5'd1;
        mem_ack = '0;
        mem_line[0] = '0;
        mem_line[1] = '0;
        hold_even = 1'b0;
        reset_and_first_packet();
        sequential_stream();
        stalled_stream();
        redirect_priority();
        stale_line_discard();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch/fetch_addr_gen.sv ====
`default_nettype none

module fetch_addr_gen (
    input wire clk,
    input wire arst_n_i,
    input wire fetch_pkg::fip_t fip_i,
    line_fill_if.gen fill,

    output logic even_req_o,
    output fetch_pkg::line_addr_t even_addr_o,
    input wire even_ack_i,
    input wire fetch_pkg::line_t even_line_i,

    output logic odd_req_o,
    output fetch_pkg::line_addr_t odd_addr_o,
    input wire odd_ack_i,
    input wire fetch_pkg::line_t odd_line_i
);

    // index 0 is the even bank, 1 the odd bank
    fetch_pkg::line_addr_t cur_line;
    fetch_pkg::line_addr_t nxt_line;
    fetch_pkg::line_addr_t need [2];
    fetch_pkg::line_addr_t held_tag_q [2];
    fetch_pkg::line_addr_t pend_tag_q [2];
    logic [1:0] held_vld_q;
    logic [1:0] pend_q;
    logic [1:0] stale_q;
    logic [1:0] ack;
    logic [1:0] req;
    logic [1:0] ready;
    logic [1:0] discard;
    logic [1:0] we;
    logic run_q;

    assign cur_line = fip_i[fetch_pkg::FIP_W-1:fetch_pkg::OFFSET_W];
    assign nxt_line = cur_line + 1'b1;
    assign ack = {odd_ack_i, even_ack_i};

    ////////////////////////////////////////////////////////////
    // per bank needed line and request decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            // L or L+1, whichever has this bank's parity
            need[b] = (cur_line[0] == b[0]) ? cur_line : nxt_line;
            ready[b] = held_vld_q[b] && (held_tag_q[b] == need[b]);
            // pointer moved away from the line in flight
            discard[b] = stale_q[b] || (pend_tag_q[b] != need[b]);
            req[b] = run_q && !ready[b] && !pend_q[b];
            we[b] = ack[b] && pend_q[b] && !discard[b];
        end
    end

    // control state
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q <= 1'b0;
            held_vld_q <= '0;
            pend_q <= '0;
            stale_q <= '0;
        end else begin
            run_q <= 1'b1;
            for (int b = 0; b < 2; b++) begin
                if (we[b]) begin
                    held_vld_q[b] <= 1'b1;
                end
                if (ack[b] && pend_q[b]) begin
                    // stale data dropped, re-request next cycle
                    pend_q[b] <= 1'b0;
                    stale_q[b] <= 1'b0;
                end else if (req[b]) begin
                    pend_q[b] <= 1'b1;
                end else if (pend_q[b] && discard[b]) begin
                    stale_q[b] <= 1'b1;
                end
            end
        end
    end

    // tags
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (req[b]) begin
                pend_tag_q[b] <= need[b];
            end
            if (we[b]) begin
                held_tag_q[b] <= pend_tag_q[b];
            end
        end
    end

    assign even_req_o = req[0];
    assign even_addr_o = need[0];
    assign odd_req_o = req[1];
    assign odd_addr_o = need[1];

    assign fill.even_we = we[0];
    assign fill.odd_we = we[1];
    assign fill.even_line = even_line_i;
    assign fill.odd_line = odd_line_i;
    assign fill.even_ready = ready[0];
    assign fill.odd_ready = ready[1];

endmodule

`default_nettype wire

// ==== fetch/fetch_pointer.sv ====
`default_nettype none

`include "fetch_defs.svh"

module fetch_pointer (
    input wire clk,
    input wire arst_n_i,
    input wire init_i,
    input wire fetch_pkg::fip_t init_addr_i,
    input wire resteer_i,
    input wire fetch_pkg::fip_t wb_fip_i,
    input wire bp_taken_i,
    input wire fetch_pkg::fip_t bp_target_i,
    input wire stall_i,
    input wire fetch_pkg::length_t d_length_i,
    input wire fetch_pkg::line_t window_i,
    input wire window_valid_i,
    output fetch_pkg::fip_t fip_o,
    output fetch_pkg::line_t packet_o,
    output logic packet_valid_o,
    output fetch_pkg::fip_t packet_fip_o
);

    fetch_pkg::fip_t fip_q;
    fetch_pkg::fip_t redirect_addr;
    fetch_pkg::fip_t next_fip;
    logic redirect;
    logic accept;

    ////////////////////////////////////////////////////////////
    // redirect select, init over resteer over branch
    ////////////////////////////////////////////////////////////

    assign redirect = init_i | resteer_i | bp_taken_i;

    always_comb begin
        if (init_i) begin
            redirect_addr = init_addr_i;
        end else if (resteer_i) begin
            redirect_addr = wb_fip_i;
        end else begin
            redirect_addr = bp_target_i;
        end
    end

    // no packet goes out while the pointer is being replaced
    assign packet_valid_o = window_valid_i & ~redirect;
    assign accept = packet_valid_o & ~stall_i;

    always_comb begin
        next_fip = fip_q;
        if (redirect) begin
            next_fip = redirect_addr;
        end else if (accept) begin
            next_fip = fip_q + fetch_pkg::fip_t'(d_length_i);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fip_q <= `FETCH_RESET_ADDR;
        end else begin
            fip_q <= next_fip;
        end
    end

    assign fip_o = fip_q;
    assign packet_o = window_i;
    assign packet_fip_o = fip_q;

endmodule

`default_nettype wire

// ==== fetch/ibuff_align.sv ====
`default_nettype none

module ibuff_align (
    input wire clk,
    input wire arst_n_i,
    line_fill_if.buff fill,
    input wire fetch_pkg::fip_t fip_i,
    output fetch_pkg::line_t window_o,
    output logic window_valid_o
);

    localparam int unsigned LINE_BITS = fetch_pkg::LINE_BITS;
    localparam int unsigned OFFSET_W = fetch_pkg::OFFSET_W;

    // slot 0 even bank, slot 1 odd bank
    fetch_pkg::line_t slot_q [2];
    logic [1:0] loaded_q;
    logic [1:0] ready;
    fetch_pkg::line_t cur_line;
    fetch_pkg::line_t nxt_line;
    logic [2*LINE_BITS-1:0] pair;
    logic [2*LINE_BITS-1:0] shifted;
    logic [OFFSET_W-1:0] offset;
    logic cur_odd;

    ////////////////////////////////////////////////////////////
    // line slots
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill.even_we) begin
            slot_q[0] <= fill.even_line;
        end
        if (fill.odd_we) begin
            slot_q[1] <= fill.odd_line;
        end
    end

    // slot has seen at least one fill
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            loaded_q <= '0;
        end else begin
            if (fill.even_we) begin
                loaded_q[0] <= 1'b1;
            end
            if (fill.odd_we) begin
                loaded_q[1] <= 1'b1;
            end
        end
    end

    assign ready = {fill.odd_ready, fill.even_ready};

    ////////////////////////////////////////////////////////////
    // ordering and byte alignment
    ////////////////////////////////////////////////////////////

    // line parity of fip picks which slot is current
    assign cur_odd = fip_i[OFFSET_W];
    assign offset = fip_i[OFFSET_W-1:0];

    always_comb begin
        if (cur_odd) begin
            cur_line = slot_q[1];
            nxt_line = slot_q[0];
        end else begin
            cur_line = slot_q[0];
            nxt_line = slot_q[1];
        end
    end

    // 32 bytes, current line in the low half
    assign pair = {nxt_line, cur_line};
    assign shifted = pair >> {offset, 3'b000};
    assign window_o = shifted[LINE_BITS-1:0];

    // both lines must be present
    assign window_valid_o = &ready && &loaded_q;

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`default_nettype none

module fetch_top (
    input wire clk,
    input wire arst_n_i,

    ////////////////////////////////////////////////////////////
    // redirects
    ////////////////////////////////////////////////////////////
    input wire init_i,
    input wire fetch_pkg::fip_t init_addr_i,
    input wire resteer_i,
    input wire fetch_pkg::fip_t wb_fip_i,
    input wire bp_taken_i,
    input wire fetch_pkg::fip_t bp_target_i,

    // decoder side
    input wire stall_i,
    input wire fetch_pkg::length_t d_length_i,
    output fetch_pkg::line_t packet_o,
    output logic packet_valid_o,
    output fetch_pkg::fip_t packet_fip_o,

    ////////////////////////////////////////////////////////////
    // instruction memory banks
    ////////////////////////////////////////////////////////////
    output logic imem_even_req_o,
    output fetch_pkg::line_addr_t imem_even_addr_o,
    input wire imem_even_ack_i,
    input wire fetch_pkg::line_t imem_even_line_i,

    output logic imem_odd_req_o,
    output fetch_pkg::line_addr_t imem_odd_addr_o,
    input wire imem_odd_ack_i,
    input wire fetch_pkg::line_t imem_odd_line_i
);

    fetch_pkg::fip_t fip;
    fetch_pkg::line_t window;
    logic window_valid;

    line_fill_if fill ();

    fetch_addr_gen u_addr_gen (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .fip_i(fip),
        .fill(fill.gen),
        .even_req_o(imem_even_req_o),
        .even_addr_o(imem_even_addr_o),
        .even_ack_i(imem_even_ack_i),
        .even_line_i(imem_even_line_i),
        .odd_req_o(imem_odd_req_o),
        .odd_addr_o(imem_odd_addr_o),
        .odd_ack_i(imem_odd_ack_i),
        .odd_line_i(imem_odd_line_i)
    );

    ibuff_align u_ibuff (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .fill(fill.buff),
        .fip_i(fip),
        .window_o(window),
        .window_valid_o(window_valid)
    );

    fetch_pointer u_pointer (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .init_i(init_i),
        .init_addr_i(init_addr_i),
        .resteer_i(resteer_i),
        .wb_fip_i(wb_fip_i),
        .bp_taken_i(bp_taken_i),
        .bp_target_i(bp_target_i),
        .stall_i(stall_i),
        .d_length_i(d_length_i),
        .window_i(window),
        .window_valid_i(window_valid),
        .fip_o(fip),
        .packet_o(packet_o),
        .packet_valid_o(packet_valid_o),
        .packet_fip_o(packet_fip_o)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/fetch_pkg.sv
common/line_fill_if.sv
fetch/fetch_addr_gen.sv
fetch/ibuff_align.sv
fetch/fetch_pointer.sv
source/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv
